//--- ps2_key_console.f
source/ps2_key_pkg.sv
source/ps2_frame_rx.sv
source/scan_decoder.sv
source/key_fifo.sv
source/char_sink.sv
source/ps2_key_console.sv
tb/ps2_key_console_assertions.sv
tb/tb_ps2_key_console.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert -Wno-fatal --top-module tb_ps2_key_console \
    -f ps2_key_console.f -o tb_ps2_key_console > build.log 2>&1 &&
    ./obj_dir/tb_ps2_key_console +verilator+error+limit+100 > sim.log 2>&1 ||
    echo "Build or simulation ended with an error status"

cat sim.log 2>/dev/null

grep -qx "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- source/char_sink.sv
`timescale 1ns/1ns

module char_sink (
    input  logic                    clk,
    input  logic                    KEY0,
    input  ps2_key_pkg::key_event_t dout,
    input  logic                    empty,
    output logic                    pop,
    output logic                    char_valid,
    output ps2_key_pkg::ascii_t     char_data,
    output logic [7:0]              leds
);
    import ps2_key_pkg::*;

    ascii_t head_char; // ASCII of the entry at the head
    logic   printable;

    // Never stalls, drain whenever something waits
    assign pop       = !empty;
    assign head_char = dout.ascii;
    assign printable = pop && (head_char != 8'h00);

    always_ff @(posedge clk or negedge KEY0) begin
        if (!KEY0) begin
            char_valid <= 1'b0;
            char_data  <= '0;
            leds       <= '0;
        end else begin
            char_valid <= printable; // Modifier-only and break events dropped here
            if (printable)
                char_data <= head_char;
            // Last character latched onto the LEDs
            if (char_valid)
                leds <= char_data;
        end
    end

endmodule

//--- source/key_fifo.sv
`timescale 1ns/1ns

module key_fifo #(
    parameter int FIFO_DEPTH = 8 // Power of two
) (
    input  logic                    clk,
    input  logic                    KEY0,
    input  logic                    push,
    input  ps2_key_pkg::key_event_t din,
    input  logic                    pop,
    output ps2_key_pkg::key_event_t dout,
    output logic                    empty,
    output logic                    overflow
);
    import ps2_key_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    key_event_t  mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr; // Extra MSB tells full from empty
    logic [AW:0] rd_ptr;
    logic        full;
    logic        do_push;
    logic        do_pop;

    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty   = (wr_ptr == rd_ptr);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Head entry always visible
    assign dout = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr[AW-1:0]] <= din;
    end

    always_ff @(posedge clk or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            // Sticky, event lost while full
            if (push && full)
                overflow <= 1'b1;
        end
    end

endmodule

//--- source/ps2_frame_rx.sv
`timescale 1ns/1ns

module ps2_frame_rx #(
    parameter int TIMEOUT_BITS = 17 // Idle counter width, wrap drops a partial frame
) (
    input  logic                clk,
    input  logic                KEY0,
    input  logic                ps2_clk,
    input  logic                ps2_dat,
    output ps2_key_pkg::frame_t frame,
    output logic                frame_error
);
    import ps2_key_pkg::*;

    logic [2:0]              clk_sync;  // [0] first stage, [2] last
    logic [2:0]              dat_sync;
    logic                    fall;      // PS/2 clock falling edge
    logic [3:0]              bit_cnt;   // Bits received so far in this frame
    logic [FRAME_BITS-1:0]   shift_reg; // LSB-first, newest bit enters at the top
    logic [TIMEOUT_BITS-1:0] idle_cnt;
    logic [FRAME_BITS-1:0]   word;      // Complete frame incl. the bit arriving now
    logic                    frame_ok;

    // Falling edge seen between the last two sync stages
    assign fall = clk_sync[2] & ~clk_sync[1];

    // Eleventh bit joins the ten already shifted in
    assign word = {dat_sync[2], shift_reg[FRAME_BITS-1:1]};

    // Start low, stop high, odd parity over data + parity bit
    assign frame_ok = !word[0] && word[FRAME_BITS-1] && (^word[9:1]);

    always_ff @(posedge clk or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync    <= '1; // Bus idles high
            dat_sync    <= '1;
            bit_cnt     <= '0;
            shift_reg   <= '0;
            idle_cnt    <= '0;
            frame       <= '0;
            frame_error <= 1'b0;
        end else begin
            clk_sync    <= {clk_sync[1:0], ps2_clk};
            dat_sync    <= {dat_sync[1:0], ps2_dat};
            frame.valid <= 1'b0; // Strobe by default

            if (fall) begin
                idle_cnt  <= '0; // Any edge restarts the idle window
                shift_reg <= word;
                if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                    bit_cnt <= '0;
                    if (frame_ok) begin
                        frame.valid <= 1'b1;
                        frame.data  <= word[8:1];
                        frame_error <= 1'b0; // Good frame clears the error
                    end else begin
                        frame_error <= 1'b1; // Held until the next good frame
                    end
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != 4'd0) begin
                // Mid-frame, waiting on the next edge
                idle_cnt <= idle_cnt + 1'b1;
                if (&idle_cnt)
                    bit_cnt <= '0; // Stalled frame dropped on wrap
            end
        end
    end

endmodule

//--- source/ps2_key_console.sv
`timescale 1ns/1ns

module ps2_key_console #(
    parameter int FIFO_DEPTH   = 8,
    parameter int TIMEOUT_BITS = 17 // About 2.6 ms at 50 MHz
) (
    input  logic                clk,
    input  logic                KEY0,
    input  logic                PS2_CLK,
    input  logic                PS2_DAT,
    output logic                char_valid,
    output ps2_key_pkg::ascii_t char_data,
    output logic [7:0]          LEDG,
    output logic                frame_error,
    output logic                overflow
);
    import ps2_key_pkg::*;

    frame_t     frame;      // Receiver to decoder
    logic       push;
    key_event_t push_event; // Decoder to buffer
    key_event_t head_event; // Buffer to consumer
    logic       empty;
    logic       pop;

    ps2_frame_rx #(.TIMEOUT_BITS(TIMEOUT_BITS)) ps2_frame_rx_inst (
        .clk(clk), .KEY0(KEY0), .ps2_clk(PS2_CLK), .ps2_dat(PS2_DAT),
        .frame(frame), .frame_error(frame_error)
    );

    scan_decoder scan_decoder_inst (
        .clk(clk), .KEY0(KEY0), .frame(frame), .push(push), .event_out(push_event)
    );

    key_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) key_fifo_inst (
        .clk(clk), .KEY0(KEY0), .push(push), .din(push_event), .pop(pop),
        .dout(head_event), .empty(empty), .overflow(overflow)
    );

    char_sink char_sink_inst (
        .clk(clk), .KEY0(KEY0), .dout(head_event), .empty(empty), .pop(pop),
        .char_valid(char_valid), .char_data(char_data), .leds(LEDG)
    );

endmodule

//--- source/ps2_key_pkg.sv
package ps2_key_pkg;

    // Raw scan byte off the wire
    typedef logic [7:0] ps2_byte_t;

    // Translated character, 0 when not printable
    typedef logic [7:0] ascii_t;

    // One received frame, valid for a single cycle
    typedef struct packed {
        ps2_byte_t data; // Scan byte, start/parity/stop stripped
        logic      valid;
    } frame_t;

    // Modifier snapshot carried with each key event
    typedef struct packed {
        logic shift;  // Either Shift held
        logic ctrl;   // Either Ctrl held
        logic alt;    // Either Alt held
        logic caps;   // Caps Lock toggle
        logic num;    // Num Lock toggle
        logic scroll; // Scroll Lock toggle
    } mod_state_t;

    // Buffer entry
    typedef struct packed {
        ps2_byte_t  scan;
        ascii_t     ascii;
        mod_state_t mods;
    } key_event_t;

    // Prefix codes, Scan Code Set 2
    localparam ps2_byte_t SC_EXTENDED = 8'hE0;
    localparam ps2_byte_t SC_BREAK    = 8'hF0;

    // Modifier make codes
    localparam ps2_byte_t SC_LSHIFT = 8'h12;
    localparam ps2_byte_t SC_RSHIFT = 8'h59;
    localparam ps2_byte_t SC_CTRL   = 8'h14; // Right Ctrl when E0-prefixed
    localparam ps2_byte_t SC_ALT    = 8'h11; // Right Alt when E0-prefixed
    localparam ps2_byte_t SC_CAPS   = 8'h58;
    localparam ps2_byte_t SC_NUM    = 8'h77;
    localparam ps2_byte_t SC_SCROLL = 8'h7E;

    // Start + 8 data + parity + stop
    localparam int FRAME_BITS = 11;

endpackage

//--- source/scan_decoder.sv
`timescale 1ns/1ns

module scan_decoder (
    input  logic                    clk,
    input  logic                    KEY0,
    input  ps2_key_pkg::frame_t     frame,
    output logic                    push,
    output ps2_key_pkg::key_event_t event_out
);
    import ps2_key_pkg::*;

    frame_t     frame_q;      // Registered receiver result
    logic       ext_q;        // E0 seen
    logic       brk_q;        // F0 seen
    logic       sft_l;
    logic       sft_r;
    logic       ctl_l;
    logic       ctl_r;
    logic       alt_l;
    logic       alt_r;
    logic       caps;
    logic       num;
    logic       scroll;
    mod_state_t mods;
    logic       shift_on;
    logic       ctrl_on;
    logic       upper;        // Letter case
    logic [4:0] letter_idx;   // 1..26 for A..Z, 0 otherwise
    ascii_t     ascii;

    assign mods     = '{shift: sft_l | sft_r, ctrl: ctl_l | ctl_r, alt: alt_l | alt_r,
                        caps: caps, num: num, scroll: scroll};
    assign shift_on = mods.shift;
    assign ctrl_on  = mods.ctrl;
    assign upper    = mods.shift ^ mods.caps;

    // Prefix and modifier tracking, one cycle behind the receiver
    always_ff @(posedge clk or negedge KEY0) begin
        if (!KEY0) begin
            frame_q <= '0;
            ext_q   <= 1'b0;
            brk_q   <= 1'b0;
            sft_l   <= 1'b0;
            sft_r   <= 1'b0;
            ctl_l   <= 1'b0;
            ctl_r   <= 1'b0;
            alt_l   <= 1'b0;
            alt_r   <= 1'b0;
            caps    <= 1'b0;
            num     <= 1'b0;
            scroll  <= 1'b0;
        end else begin
            frame_q <= frame;
            if (frame_q.valid) begin
                if (brk_q) begin
                    // Break code completes, release held modifiers
                    brk_q <= 1'b0;
                    ext_q <= 1'b0;
                    case (frame_q.data)
                        SC_LSHIFT: sft_l <= 1'b0;
                        SC_RSHIFT: sft_r <= 1'b0;
                        SC_CTRL:   if (ext_q) ctl_r <= 1'b0; else ctl_l <= 1'b0;
                        SC_ALT:    if (ext_q) alt_r <= 1'b0; else alt_l <= 1'b0;
                        default:   ;
                    endcase
                end else begin
                    case (frame_q.data)
                        SC_EXTENDED: ext_q  <= 1'b1;
                        SC_BREAK:    brk_q  <= 1'b1; // E0 stays for E0 F0 xx
                        SC_CAPS:     caps   <= ~caps;
                        SC_NUM:      num    <= ~num;
                        SC_SCROLL:   scroll <= ~scroll;
                        SC_LSHIFT:   sft_l  <= 1'b1;
                        SC_RSHIFT:   sft_r  <= 1'b1;
                        SC_CTRL:     if (ext_q) ctl_r <= 1'b1; else ctl_l <= 1'b1;
                        SC_ALT:      if (ext_q) alt_r <= 1'b1; else alt_l <= 1'b1;
                        default:     ;
                    endcase
                    // Extended make consumed
                    if (frame_q.data != SC_EXTENDED && frame_q.data != SC_BREAK)
                        ext_q <= 1'b0;
                end
            end
        end
    end

    // Letter index, shared by case and control-code paths
    always_comb begin
        case (frame_q.data)
            8'h1C:   letter_idx = 5'd1;  // A
            8'h32:   letter_idx = 5'd2;  // B
            8'h21:   letter_idx = 5'd3;  // C
            8'h23:   letter_idx = 5'd4;  // D
            8'h24:   letter_idx = 5'd5;  // E
            8'h2B:   letter_idx = 5'd6;  // F
            8'h34:   letter_idx = 5'd7;  // G
            8'h33:   letter_idx = 5'd8;  // H
            8'h43:   letter_idx = 5'd9;  // I
            8'h3B:   letter_idx = 5'd10; // J
            8'h42:   letter_idx = 5'd11; // K
            8'h4B:   letter_idx = 5'd12; // L
            8'h3A:   letter_idx = 5'd13; // M
            8'h31:   letter_idx = 5'd14; // N
            8'h44:   letter_idx = 5'd15; // O
            8'h4D:   letter_idx = 5'd16; // P
            8'h15:   letter_idx = 5'd17; // Q
            8'h2D:   letter_idx = 5'd18; // R
            8'h1B:   letter_idx = 5'd19; // S
            8'h2C:   letter_idx = 5'd20; // T
            8'h3C:   letter_idx = 5'd21; // U
            8'h2A:   letter_idx = 5'd22; // V
            8'h1D:   letter_idx = 5'd23; // W
            8'h22:   letter_idx = 5'd24; // X
            8'h35:   letter_idx = 5'd25; // Y
            8'h1A:   letter_idx = 5'd26; // Z
            default: letter_idx = 5'd0;
        endcase
    end

    // Scan Code Set 2 to ASCII, break events give 0
    always_comb begin
        ascii = 8'h00;
        if (!brk_q && ext_q) begin
            case (frame_q.data)
                8'h71:   ascii = 8'h7F; // Delete
                8'h4A:   ascii = 8'h2F; // Keypad /
                8'h5A:   ascii = 8'h0D; // Keypad Enter
                default: ascii = 8'h00; // Arrows, nav block, right Ctrl/Alt
            endcase
        end else if (!brk_q) begin
            case (frame_q.data)
                8'h16: ascii = shift_on ? 8'h21 : 8'h31; // ! 1
                8'h1E: ascii = shift_on ? 8'h40 : 8'h32; // @ 2
                8'h26: ascii = shift_on ? 8'h23 : 8'h33; // # 3
                8'h25: ascii = shift_on ? 8'h24 : 8'h34; // $ 4
                8'h2E: ascii = shift_on ? 8'h25 : 8'h35; // % 5
                8'h36: ascii = ctrl_on ? 8'h1E : (shift_on ? 8'h5E : 8'h36); // ^ 6
                8'h3D: ascii = shift_on ? 8'h26 : 8'h37; // & 7
                8'h3E: ascii = shift_on ? 8'h2A : 8'h38; // * 8
                8'h46: ascii = shift_on ? 8'h28 : 8'h39; // ( 9
                8'h45: ascii = shift_on ? 8'h29 : 8'h30; // ) 0
                8'h0E: ascii = shift_on ? 8'h7E : 8'h60; // ~ `
                8'h4E: ascii = ctrl_on ? 8'h1F : (shift_on ? 8'h5F : 8'h2D); // _ -
                8'h55: ascii = shift_on ? 8'h2B : 8'h3D; // + =
                8'h54: ascii = ctrl_on ? 8'h1B : (shift_on ? 8'h7B : 8'h5B); // { [
                8'h5B: ascii = ctrl_on ? 8'h1D : (shift_on ? 8'h7D : 8'h5D); // } ]
                8'h5D: ascii = ctrl_on ? 8'h1C : (shift_on ? 8'h7C : 8'h5C); // | backslash
                8'h4C: ascii = shift_on ? 8'h3A : 8'h3B; // : ;
                8'h52: ascii = shift_on ? 8'h22 : 8'h27; // " '
                8'h41: ascii = shift_on ? 8'h3C : 8'h2C; // < ,
                8'h49: ascii = shift_on ? 8'h3E : 8'h2E; // > .
                8'h4A: ascii = ctrl_on ? 8'h7F : (shift_on ? 8'h3F : 8'h2F); // ? /
                8'h29: ascii = 8'h20; // Space
                8'h66: ascii = 8'h08; // Backspace
                8'h5A: ascii = 8'h0D; // Enter
                8'h76: ascii = 8'h1B; // Escape
                8'h0D: ascii = 8'h09; // Tab
                8'h69: ascii = num ? 8'h31 : 8'h00; // Keypad digits need Num Lock
                8'h72: ascii = num ? 8'h32 : 8'h00;
                8'h7A: ascii = num ? 8'h33 : 8'h00;
                8'h6B: ascii = num ? 8'h34 : 8'h00;
                8'h73: ascii = num ? 8'h35 : 8'h00;
                8'h74: ascii = num ? 8'h36 : 8'h00;
                8'h6C: ascii = num ? 8'h37 : 8'h00;
                8'h75: ascii = num ? 8'h38 : 8'h00;
                8'h7D: ascii = num ? 8'h39 : 8'h00;
                8'h70: ascii = num ? 8'h30 : 8'h00;
                8'h7C: ascii = 8'h2A; // Keypad *
                8'h7B: ascii = 8'h2D; // Keypad -
                8'h79: ascii = 8'h2B; // Keypad +
                8'h71: ascii = 8'h2E; // Keypad .
                default: begin
                    // Ctrl gives 01..1A, else 40+n or 60+n
                    if (letter_idx != 5'd0)
                        ascii = ctrl_on ? {3'b000, letter_idx} : {2'b01, !upper, letter_idx};
                end
            endcase
        end
    end

    // Every non-prefix make and every completed break is an event
    assign push = frame_q.valid &&
                  (brk_q || (frame_q.data != SC_EXTENDED && frame_q.data != SC_BREAK));
    assign event_out = '{scan: frame_q.data, ascii: ascii, mods: mods};

endmodule

//--- tb/ps2_key_console_assertions.sv
`timescale 1ns/1ns

module ps2_key_console_assertions (
    input logic                clk,
    input logic                KEY0,
    input logic                char_valid,
    input ps2_key_pkg::ascii_t char_data,
    input logic [7:0]          LEDG,
    input logic                frame_error,
    input logic                overflow,
    input logic                push,  // Decoder into buffer
    input logic                empty
);
    import ps2_key_pkg::*;

    int unsigned fail_count = 0; // Failed assertions so far
    ascii_t      last_char;      // char_data one cycle back

    always_ff @(posedge clk or negedge KEY0) begin
        if (!KEY0)
            last_char <= '0;
        else
            last_char <= char_data;
    end

    // Character strobe lasts one cycle
    strobe_single: assert property (@(posedge clk) disable iff (!KEY0)
        char_valid |=> !char_valid)
        else begin
            fail_count++;
            $error("char_valid stayed high for two cycles");
        end

    // Consumer never stalls, so no event may be lost
    no_overflow: assert property (@(posedge clk) disable iff (!KEY0) !overflow)
        else begin
            fail_count++;
            $error("overflow rose in the key buffer");
        end

    // Values held while KEY0 is low
    reset_state: assert property (@(posedge clk)
        !KEY0 |-> (!char_valid && !frame_error && LEDG == 8'h00 && empty && !overflow))
        else begin
            fail_count++;
            $error("Outputs not at reset values while KEY0 low");
        end

    // LEDs latch the character shown one cycle earlier
    leds_follow: assert property (@(posedge clk) disable iff (!KEY0)
        char_valid |=> (LEDG == last_char))
        else begin
            fail_count++;
            $error("Fail: LEDG = %h, expected %h", $sampled(LEDG), $sampled(last_char));
        end

    // Write into an empty buffer is visible next cycle
    push_lands: assert property (@(posedge clk) disable iff (!KEY0)
        (push && empty) |=> !empty)
        else begin
            fail_count++;
            $error("Buffer still empty after a push");
        end

endmodule

bind ps2_key_console ps2_key_console_assertions assertions_inst (
    .clk(clk), .KEY0(KEY0), .char_valid(char_valid), .char_data(char_data),
    .LEDG(LEDG), .frame_error(frame_error), .overflow(overflow),
    .push(push), .empty(empty)
);

//--- tb/tb_ps2_key_console.sv
`timescale 1ns/1ns

module tb_ps2_key_console;
    import ps2_key_pkg::*;

    localparam int PS2_HALF     = 8;  // PS/2 clock half-period, in clk cycles
    localparam int TIMEOUT_BITS = 10;
    localparam int IDLE_GAP     = 2 ** TIMEOUT_BITS + 50; // Past one idle-counter wrap
    localparam int FRAME_COUNT  = 57; // Frames sent over the whole run
    localparam int WATCHDOG_CYCLES = FRAME_COUNT * FRAME_BITS * 2 * PS2_HALF + IDLE_GAP + 3000;
    localparam logic [31:0] SEED = 32'h1f3f_49f9;

    // Set 2 make codes, A..Z
    localparam ps2_byte_t LETTER_SCAN [26] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
        8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
        8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};

    logic       clk;
    logic       KEY0;
    logic       PS2_CLK;
    logic       PS2_DAT;
    logic       char_valid;
    ascii_t     char_data;
    logic [7:0] LEDG;
    logic       frame_error;
    logic       overflow;

    ascii_t     exp_chars [64]; // Circular queue of expected characters
    logic [5:0] wr_idx   = '0;
    logic [5:0] rd_idx   = '0;
    ascii_t     exp_head;
    logic       bad_sent = 1'b0; // High while a corrupted frame is on the wire

    ps2_key_console #(.FIFO_DEPTH(8), .TIMEOUT_BITS(TIMEOUT_BITS)) ps2_key_console_inst (
        .clk(clk), .KEY0(KEY0), .PS2_CLK(PS2_CLK), .PS2_DAT(PS2_DAT),
        .char_valid(char_valid), .char_data(char_data), .LEDG(LEDG),
        .frame_error(frame_error), .overflow(overflow)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    assign exp_head = exp_chars[rd_idx];

    always @(posedge clk) begin
        if (char_valid && rd_idx != wr_idx)
            rd_idx <= rd_idx + 6'd1; // Character consumed
    end

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Letter n as lower, upper or Ctrl code
    function automatic ascii_t letter_ascii(input int idx, input logic upper, input logic ctrl);
        if (ctrl)
            return ascii_t'(idx + 1); // Ctrl-A is 01
        else if (upper)
            return ascii_t'(8'h41 + idx);
        else
            return ascii_t'(8'h61 + idx);
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2; // Drive point after the edge
    endtask

    task automatic expect_char(input ascii_t ch);
        exp_chars[wr_idx] = ch;
        wr_idx = wr_idx + 6'd1;
    endtask

    // Device-side frame, LSB first, data changes while the clock is high
    task automatic send_frame(input ps2_byte_t data, input logic bad_parity, input int nbits);
        logic [10:0] bits;
        bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0}; // Stop, odd parity, data, start
        for (int i = 0; i < nbits; i++) begin
            PS2_DAT = bits[i];
            wait_cycles(PS2_HALF);
            PS2_CLK = 1'b0; // Receiver samples here
            wait_cycles(PS2_HALF);
            PS2_CLK = 1'b1;
        end
        PS2_DAT = 1'b1;
    endtask

    task automatic send_byte(input ps2_byte_t data);
        send_frame(data, 1'b0, FRAME_BITS);
    endtask

    task automatic send_key(input ps2_byte_t scan, input ascii_t ch);
        expect_char(ch);
        send_byte(scan);
    endtask

    task automatic drain(input int limit);
        int n;
        n = 0;
        while (rd_idx != wr_idx && n < limit) begin
            wait_cycles(1);
            n++;
        end
    endtask

    task automatic check_frame_error(input logic expected);
        assert (frame_error == expected) else begin
            $display("Fail: frame_error = %h, expected %h", frame_error, expected);
            abort_run();
        end
    endtask

    // Each strobe must be expected, and match the queue head
    char_expected: assert property (@(posedge clk) disable iff (!KEY0)
        char_valid |-> (rd_idx != wr_idx))
        else begin
            $display("Character %h arrived while none was expected", $sampled(char_data));
            abort_run();
        end

    char_matches: assert property (@(posedge clk) disable iff (!KEY0)
        (char_valid && rd_idx != wr_idx) |-> (char_data == exp_head))
        else begin
            $display("Fail: char_data = %h, expected %h", $sampled(char_data),
                     $sampled(exp_head));
            abort_run();
        end

    error_only_on_bad: assert property (@(posedge clk) disable iff (!KEY0)
        $rose(frame_error) |-> bad_sent)
        else begin
            $display("frame_error rose on a frame that was sent correctly");
            abort_run();
        end

    // Bound checkers count their failures
    always @(posedge clk) begin
        if (ps2_key_console_inst.assertions_inst.fail_count != 0) begin
            $display("A bound assertion on the DUT failed");
            abort_run();
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout, stimulus did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        logic [31:0] rng;
        int          idx;
        KEY0    = 1'b1;
        PS2_CLK = 1'b1; // Bus idle
        PS2_DAT = 1'b1;
        #1 KEY0 = 1'b0;
        repeat (2) @(posedge clk);
        #2 KEY0 = 1'b1;
        wait_cycles(4);

        // Plain make codes, break gives nothing
        send_key(8'h1C, letter_ascii(0, 1'b0, 1'b0));
        send_key(8'h45, 8'h30);
        send_key(8'h29, 8'h20);
        send_byte(SC_BREAK);
        send_byte(8'h1C);
        drain(200);

        // Shift, then Caps Lock on and off
        send_byte(SC_LSHIFT);
        send_key(8'h1C, letter_ascii(0, 1'b1, 1'b0));
        send_key(8'h16, 8'h21);
        send_byte(SC_BREAK);
        send_byte(SC_LSHIFT);
        send_key(8'h1C, letter_ascii(0, 1'b0, 1'b0));
        send_byte(SC_CAPS);
        send_key(8'h1C, letter_ascii(0, 1'b1, 1'b0));
        send_key(8'h16, 8'h31); // Caps leaves digits alone
        send_byte(SC_CAPS);
        send_key(8'h1C, letter_ascii(0, 1'b0, 1'b0));
        drain(200);

        // Ctrl code, right Ctrl press and release
        send_byte(SC_CTRL);
        send_key(8'h21, letter_ascii(2, 1'b0, 1'b1));
        send_byte(SC_BREAK);
        send_byte(SC_CTRL);
        send_byte(SC_EXTENDED);
        send_byte(SC_CTRL);
        send_byte(SC_EXTENDED);
        send_byte(SC_BREAK);
        send_byte(SC_CTRL);
        send_key(8'h21, letter_ascii(2, 1'b0, 1'b0)); // Ctrl must be clear again
        send_byte(SC_EXTENDED);
        send_key(8'h5A, 8'h0D); // Keypad Enter
        send_byte(SC_EXTENDED);
        send_key(8'h71, 8'h7F); // Delete
        send_byte(8'h69); // Keypad 1, Num Lock off
        send_byte(SC_NUM);
        send_key(8'h69, 8'h31);
        drain(200);

        // Bad parity, then recovery
        bad_sent = 1'b1;
        send_frame(8'h1C, 1'b1, FRAME_BITS);
        check_frame_error(1'b1);
        bad_sent = 1'b0;
        send_key(8'h1C, letter_ascii(0, 1'b0, 1'b0));
        check_frame_error(1'b0);
        drain(200);

        // Partial frame dropped by the idle timeout
        send_frame(8'h1C, 1'b0, 5);
        wait_cycles(IDLE_GAP);
        send_key(8'h1C, letter_ascii(0, 1'b0, 1'b0));
        check_frame_error(1'b0);
        drain(200);

        // Back-to-back random letters
        rng = SEED;
        for (int i = 0; i < 20; i++) begin
            rng = xorshift32(rng);
            idx = int'(rng % 32'd26);
            send_key(LETTER_SCAN[idx], letter_ascii(idx, 1'b0, 1'b0));
        end

        drain(200);
        wait_cycles(20); // Room for any stray strobe
        if (rd_idx != wr_idx) begin
            $display("%0d expected characters never arrived", 6'(wr_idx - rd_idx));
            abort_run();
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule
